// File: canPkg.sv
/* Shared widths, CAN constants, FSM state and error enums,
   and the decoded-frame struct for the CAN receive decoder */

`default_nettype none

package canPkg;

  // ----------------------------------------
  // Field widths
  // ----------------------------------------
  localparam int unsigned IdStdBits    = 11;  // Base identifier
  localparam int unsigned IdExtBits    = 18;  // Identifier extension
  localparam int unsigned IdBits       = 29;  // Base plus extension
  localparam int unsigned DlcBits      = 4;   // Raw DLC field
  localparam int unsigned MaxDataBytes = 8;   // Clamp for DLC 9..15
  localparam int unsigned CrcBits      = 15;  // CAN CRC-15

  // ----------------------------------------
  // Bus constants
  // ----------------------------------------
  localparam logic [CrcBits-1:0] CrcPoly = 15'h4599;  // x15+x14+x10+x8+x7+x4+x3+1
  localparam int unsigned EofBits       = 7;    // Recessive EOF bits
  localparam int unsigned StuffRun      = 5;    // Equal bits before a stuff bit
  localparam int unsigned IdleRecessive = 11;   // Bus idle after an error

  // Counter widths
  localparam int unsigned RunBits = 3;  // Holds StuffRun
  localparam int unsigned CntBits = 7;  // Holds 64 data bits

  // ----------------------------------------
  // Decoder states
  // ----------------------------------------
  // CRC sequence state is CrcSeq, Crc belongs to the error kinds
  typedef enum logic [3:0] {
    Idle,           // Wait for SOF
    IdA,            // 11 base id bits
    SrrRtr,         // RTR (std) or SRR (ext)
    Ide,            // Selects the id path
    IdB,            // 18 extension bits
    RtrExt,         // RTR of extended frame
    Reserved,       // r0, or r1 r0
    Dlc,            // 4 length bits
    Data,           // 0..64 data bits
    CrcSeq,         // 15 received CRC bits
    CrcDelim,       // Must be recessive
    AckSlot,        // Either level
    AckDelim,       // Must be recessive
    Eof,            // 7 recessive bits
    ErrorRecovery   // Wait for bus idle
  } canFieldE;

  typedef enum logic [1:0] {
    None,   // No error yet
    Stuff,  // Six equal bits
    Crc,    // CRC mismatch
    Form    // Dominant fixed-form bit
  } canErrorE;

  // One decoded frame
  typedef struct packed {
    logic                              ide;      // Extended format
    logic                              rtr;      // Remote frame
    logic [IdBits-1:0]                 id;       // Std id in low 11 bits
    logic [DlcBits-1:0]                dlc;      // Raw, unclamped
    logic [MaxDataBytes-1:0][7:0]      data;     // First byte in top byte
    logic                              srrWarn;  // SRR was dominant
    logic                              resWarn;  // A reserved bit was dominant
  } canFrameT;

endpackage

`default_nettype wire

// File: canBitDestuffer.sv
/* Bit destuffer: run-length tracking, stuff bit removal
   and stuff error detection on the sampled bus bits */

`default_nettype none

module canBitDestuffer
  import canPkg::*;
(
  input  logic Clock_SP,
  input  logic rstN,
  input  logic bitValid,     // One strobe per bus bit
  input  logic busBit,       // 1 = recessive
  input  logic stuffEnable,  // Stuffed region of the frame
  output logic dataValid,    // Destuffed bit strobe
  output logic dataBit,
  output logic stuffError    // Sixth equal bit seen
);

  logic               prevBit;   // Level of last bus bit
  logic [RunBits-1:0] runLen;    // Equal bits so far, saturates
  logic               stuffSlot; // Incoming bit must be a stuff bit
  logic               sameBit;   // Incoming bit extends the run

  assign stuffSlot = stuffEnable && (runLen == RunBits'(StuffRun));
  assign sameBit   = (busBit == prevBit);

  always_ff @(posedge Clock_SP or negedge rstN)
  begin
    if (!rstN)
    begin
      prevBit    <= 1'b1;   // Bus idles recessive
      runLen     <= '0;
      dataValid  <= 1'b0;
      stuffError <= 1'b0;
    end
    else
    begin
      dataValid  <= 1'b0;   // Strobes last one cycle
      stuffError <= 1'b0;
      if (bitValid)
      begin
        prevBit <= busBit;
        if (stuffSlot && sameBit)
          stuffError <= 1'b1;            // Missing stuff bit
        else if (stuffSlot)
          runLen <= RunBits'(1);         // Stuff bit dropped, new run
        else
        begin
          dataValid <= 1'b1;             // Pass the bit on
          if (!sameBit)
            runLen <= RunBits'(1);
          else if (runLen != RunBits'(StuffRun))
            runLen <= runLen + 1'b1;     // Saturate outside stuffing
        end
      end
    end
  end

  // Bit value only, qualified by dataValid
  always_ff @(posedge Clock_SP)
  begin
    if (bitValid)
      dataBit <= busBit;
  end

endmodule

`default_nettype wire

// File: canCrc15.sv
/* CAN CRC-15 shift register over the destuffed bits */

`default_nettype none

module canCrc15
  import canPkg::*;
(
  input  logic               Clock_SP,
  input  logic               rstN,
  input  logic               crcClear,   // Pulse at start of frame
  input  logic               crcEnable,  // SOF through last data bit
  input  logic               dataValid,  // Destuffed bit strobe
  input  logic               dataBit,
  output logic [CrcBits-1:0] crcValue
);

  logic crcNext;  // Feedback into the polynomial taps

  assign crcNext = dataBit ^ crcValue[CrcBits-1];

  // SOF is dominant, so from a cleared register it shifts in zeros only;
  // clearing just after SOF gives the same remainder
  always_ff @(posedge Clock_SP or negedge rstN)
  begin
    if (!rstN)
      crcValue <= '0;
    else if (crcClear)
      crcValue <= '0;                            // New frame
    else if (dataValid && crcEnable)
      crcValue <= {crcValue[CrcBits-2:0], 1'b0}
                  ^ (CrcPoly & {CrcBits{crcNext}}); // One LFSR step
  end

endmodule

`default_nettype wire

// File: canFieldDecoder.sv
/* Field FSM of the CAN decoder: identifier, control, data and CRC capture,
   form and CRC checks, frame and error reporting, error recovery */

`default_nettype none

module canFieldDecoder
  import canPkg::*;
(
  input  logic               Clock_SP,
  input  logic               rstN,
  input  logic               dataValid,    // Destuffed bit strobe
  input  logic               dataBit,
  input  logic               stuffError,   // From the destuffer
  input  logic [CrcBits-1:0] crcValue,     // Computed CRC
  output logic               stuffEnable,  // Stuffed region
  output logic               crcEnable,    // CRC-covered region
  output logic               crcClear,     // Pulse after SOF
  output logic               frameValid,   // Good frame strobe
  output canFrameT           frameInfo,
  output logic               frameError,   // Error strobe
  output canErrorE           errorKind
);

  canFieldE           state;
  logic [CntBits-1:0] bitCnt;     // Bit index in current field
  logic [CntBits-1:0] dataEnd;    // Index of the last data bit
  canFrameT           cur;        // Frame being assembled
  logic [CrcBits-1:0] crcRx;      // Received CRC field
  logic [DlcBits-1:0] dlcNext;    // DLC with the arriving bit
  logic [DlcBits-1:0] dlcClamp;   // Data bytes, max 8
  logic               noData;     // Remote frame or DLC 0
  logic               frameDone;  // Last EOF bit, recessive
  canErrorE           errNext;    // Error decided by this bit

  // ----------------------------------------
  // Combinational helpers
  // ----------------------------------------
  assign dlcNext  = {cur.dlc[DlcBits-2:0], dataBit};
  assign dlcClamp = (dlcNext > DlcBits'(MaxDataBytes)) ? DlcBits'(MaxDataBytes) : dlcNext;
  assign noData   = cur.rtr || (dlcNext == '0);
  assign frameDone = dataValid && (state == Eof) && dataBit
                     && (bitCnt == CntBits'(EofBits - 1));

  always_comb
  begin
    errNext = None;
    if (stuffError && stuffEnable)
      errNext = Stuff;                     // Any stuffed field
    else if (dataValid)
    begin
      case (state)
        CrcDelim:
        begin
          if (!dataBit)
            errNext = Form;                // Delimiter wins over CRC
          else if (crcRx != crcValue)
            errNext = Crc;
        end
        AckDelim, Eof:
        begin
          if (!dataBit)
            errNext = Form;                // Fixed recessive bits
        end
        default:
        begin
          errNext = None;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  always_ff @(posedge Clock_SP or negedge rstN)
  begin
    if (!rstN)
    begin
      state       <= Idle;
      bitCnt      <= '0;
      stuffEnable <= 1'b0;
      crcEnable   <= 1'b0;
      crcClear    <= 1'b0;
      frameValid  <= 1'b0;
      frameError  <= 1'b0;
      errorKind   <= None;
    end
    else
    begin
      crcClear   <= 1'b0;   // Pulses
      frameValid <= 1'b0;
      frameError <= 1'b0;
      if (errNext != None)
      begin
        frameError  <= 1'b1;
        errorKind   <= errNext;   // Held until next error
        state       <= ErrorRecovery;
        bitCnt      <= '0;
        stuffEnable <= 1'b0;
        crcEnable   <= 1'b0;
      end
      else if (dataValid)
      begin
        bitCnt <= bitCnt + 1'b1;  // Default advance
        case (state)
          Idle:
          begin
            bitCnt <= '0;
            if (!dataBit)                  // SOF
            begin
              state       <= IdA;
              stuffEnable <= 1'b1;
              crcEnable   <= 1'b1;
              crcClear    <= 1'b1;
            end
          end
          IdA:
          begin
            if (bitCnt == CntBits'(IdStdBits - 1))
            begin
              state  <= SrrRtr;
              bitCnt <= '0;
            end
          end
          SrrRtr:
          begin
            state <= Ide;
          end
          Ide:
          begin
            state  <= dataBit ? IdB : Reserved;  // Recessive IDE = extended
            bitCnt <= '0;
          end
          IdB:
          begin
            if (bitCnt == CntBits'(IdExtBits - 1))
            begin
              state  <= RtrExt;
              bitCnt <= '0;
            end
          end
          RtrExt:
          begin
            state  <= Reserved;
            bitCnt <= '0;
          end
          Reserved:
          begin
            if (bitCnt == CntBits'(cur.ide))     // 1 bit std, 2 bits ext
            begin
              state  <= Dlc;
              bitCnt <= '0;
            end
          end
          Dlc:
          begin
            if (bitCnt == CntBits'(DlcBits - 1))
            begin
              bitCnt <= '0;
              if (noData)
              begin
                state     <= CrcSeq;       // Skip data field
                crcEnable <= 1'b0;
              end
              else
                state <= Data;
            end
          end
          Data:
          begin
            if (bitCnt == dataEnd)
            begin
              state     <= CrcSeq;
              crcEnable <= 1'b0;           // CRC covers up to here
              bitCnt    <= '0;
            end
          end
          CrcSeq:
          begin
            if (bitCnt == CntBits'(CrcBits - 1))
              state <= CrcDelim;
          end
          CrcDelim:
          begin
            state       <= AckSlot;
            stuffEnable <= 1'b0;           // End of stuffed region
          end
          AckSlot:
          begin
            state <= AckDelim;             // Monitor takes any level
          end
          AckDelim:
          begin
            state  <= Eof;
            bitCnt <= '0;
          end
          Eof:
          begin
            if (frameDone)
            begin
              frameValid <= 1'b1;
              state      <= Idle;
              bitCnt     <= '0;
            end
          end
          ErrorRecovery:
          begin
            if (!dataBit)
              bitCnt <= '0;                // Restart idle count
            else if (bitCnt == CntBits'(IdleRecessive - 1))
            begin
              state  <= Idle;
              bitCnt <= '0;
            end
          end
          default:
          begin
            state <= Idle;
          end
        endcase
      end
    end
  end

  // ----------------------------------------
  // Field capture
  // ----------------------------------------
  always_ff @(posedge Clock_SP)
  begin
    if (dataValid)
    begin
      case (state)
        Idle:     cur <= '0;                                 // Clean start
        IdA, IdB: cur.id <= {cur.id[IdBits-2:0], dataBit};   // Base ends on top if ext
        SrrRtr:   cur.rtr <= dataBit;                        // SRR if extended
        Ide:
        begin
          cur.ide     <= dataBit;
          cur.srrWarn <= dataBit & ~cur.rtr;                 // Dominant SRR
        end
        RtrExt:   cur.rtr <= dataBit;
        Reserved: cur.resWarn <= cur.resWarn | ~dataBit;
        Dlc:
        begin
          cur.dlc <= dlcNext;
          dataEnd <= CntBits'({dlcClamp, 3'b000}) - 1'b1;    // Bytes to last bit
        end
        Data:     cur.data[~bitCnt[5:3]][~bitCnt[2:0]] <= dataBit;  // MSB first
        CrcSeq:   crcRx <= {crcRx[CrcBits-2:0], dataBit};
        default:  crcRx <= crcRx;
      endcase
    end
    if (frameDone)
      frameInfo <= cur;  // Valid with frameValid
  end

endmodule

`default_nettype wire

// File: canDecoder.sv
/* Top level of the CAN receive decoder: destuffer, CRC-15 unit
   and field FSM */

`default_nettype none

module canDecoder
  import canPkg::*;
(
  input  logic     Clock_SP,
  input  logic     rstN,
  input  logic     bitValid,    // Sampled bit strobe
  input  logic     busBit,      // 1 = recessive
  output logic     frameValid,  // Good frame strobe
  output canFrameT frameInfo,
  output logic     frameError,  // Error strobe
  output canErrorE errorKind
);

  // ----------------------------------------
  // Internal links
  // ----------------------------------------
  logic               dataValid;    // Destuffed bit strobe
  logic               dataBit;
  logic               stuffError;
  logic               stuffEnable;  // From the FSM
  logic               crcEnable;
  logic               crcClear;
  logic [CrcBits-1:0] crcValue;

  canBitDestuffer destuffer (
    .Clock_SP    (Clock_SP),
    .rstN        (rstN),
    .bitValid    (bitValid),
    .busBit      (busBit),
    .stuffEnable (stuffEnable),
    .dataValid   (dataValid),
    .dataBit     (dataBit),
    .stuffError  (stuffError)
  );

  canCrc15 crcUnit (
    .Clock_SP  (Clock_SP),
    .rstN      (rstN),
    .crcClear  (crcClear),
    .crcEnable (crcEnable),
    .dataValid (dataValid),
    .dataBit   (dataBit),
    .crcValue  (crcValue)
  );

  canFieldDecoder fieldDecoder (
    .Clock_SP    (Clock_SP),
    .rstN        (rstN),
    .dataValid   (dataValid),
    .dataBit     (dataBit),
    .stuffError  (stuffError),
    .crcValue    (crcValue),
    .stuffEnable (stuffEnable),
    .crcEnable   (crcEnable),
    .crcClear    (crcClear),
    .frameValid  (frameValid),
    .frameInfo   (frameInfo),
    .frameError  (frameError),
    .errorKind   (errorKind)
  );

endmodule

`default_nettype wire

// File: canFrameGen.svh
/* Frame builder for the testbench: field serializer, reference CRC-15,
   bit stuffing, fixed frame tail and the positions used for corruptions */

`ifndef CAN_FRAME_GEN_SVH
`define CAN_FRAME_GEN_SVH

bit rawBits[$];    // SOF through CRC, unstuffed
bit lineBits[$];   // SOF through EOF as driven on the bus
int dataStart;     // First data bit, or first CRC bit, in rawBits
int firstStuff;    // First stuff bit in lineBits, -1 if none
int delimPos;      // CRC delimiter in lineBits

// Data field length in bytes
function automatic int dataBytes(input canFrameT f);
  if (f.rtr)
    return 0;                                   // Remote frame carries no data
  return (int'(f.dlc) > 8) ? 8 : int'(f.dlc);   // Clamp for DLC 9..15
endfunction

// Append a field MSB first
function automatic void pushField(input logic [63:0] value, input int width);
  int i;
  for (i = width - 1; i >= 0; i--)
    rawBits.push_back(value[i]);
endfunction

// CAN CRC-15 over the first count bits of rawBits
function automatic logic [CrcBits-1:0] crcOf(input int count);
  logic [CrcBits-1:0] crc;
  logic               fb;
  int                 i;
  crc = '0;
  for (i = 0; i < count; i++)
  begin
    fb  = rawBits[i] ^ crc[CrcBits-1];
    crc = {crc[CrcBits-2:0], 1'b0};
    if (fb)
      crc = crc ^ CrcPoly;
  end
  return crc;
endfunction

// Unstuffed bits of a frame, CRC appended
function automatic void serialize(input canFrameT f);
  int i;
  rawBits.delete();
  rawBits.push_back(1'b0);                                 // SOF
  if (f.ide)
  begin
    pushField(64'(f.id[IdBits-1 -: IdStdBits]), IdStdBits);  // Base id
    rawBits.push_back(~f.srrWarn);                         // SRR
    rawBits.push_back(1'b1);                               // IDE
    pushField(64'(f.id[IdExtBits-1:0]), IdExtBits);
    rawBits.push_back(f.rtr);
    rawBits.push_back(~f.resWarn);                         // r1
    rawBits.push_back(~f.resWarn);                         // r0
  end
  else
  begin
    pushField(64'(f.id[IdStdBits-1:0]), IdStdBits);
    rawBits.push_back(f.rtr);
    rawBits.push_back(1'b0);                               // IDE dominant
    rawBits.push_back(~f.resWarn);                         // r0
  end
  pushField(64'(f.dlc), DlcBits);
  dataStart = rawBits.size();
  for (i = 0; i < dataBytes(f); i++)
    pushField(64'(f.data[MaxDataBytes-1-i]), 8);           // First byte on top
  pushField(64'(crcOf(rawBits.size())), CrcBits);
endfunction

// Stuffed line bits plus delimiters, ACK and EOF
function automatic void stuffLine(input bit ackBit);
  int i;
  int run;
  bit last;
  lineBits.delete();
  firstStuff = -1;
  run        = 0;
  last       = 1'b1;                 // Bus idles recessive before SOF
  for (i = 0; i < rawBits.size(); i++)
  begin
    lineBits.push_back(rawBits[i]);
    run  = (rawBits[i] == last) ? run + 1 : 1;
    last = rawBits[i];
    if (run == StuffRun)
    begin
      if (firstStuff < 0)
        firstStuff = lineBits.size();
      lineBits.push_back(~last);     // Also after the last CRC bit
      last = ~last;
      run  = 1;
    end
  end
  delimPos = lineBits.size();
  lineBits.push_back(1'b1);          // CRC delimiter
  lineBits.push_back(ackBit);        // ACK slot
  lineBits.push_back(1'b1);          // ACK delimiter
  for (i = 0; i < EofBits; i++)
    lineBits.push_back(1'b1);
endfunction

`endif

// File: canDecoderTb.sv
/* Testbench for the CAN decoder: clock, reset, random frames with
   corruptions, outcome scoreboard and cycle limit */

`default_nettype none

module canDecoderTb
  import canPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumFrames  = 61;                           // Ends on a clean frame
  localparam int CycleLimit = NumFrames * 160 * 4 * 2 + 400;  // Plus reset and idle bits

  typedef struct packed {
    logic     isError;
    canErrorE kind;
    canFrameT frame;
  } outcomeT;

  logic     Clock_SP = 1'b0;
  logic     rstN;
  logic     bitValid;
  logic     busBit;
  logic     frameValid;
  canFrameT frameInfo;
  logic     frameError;
  canErrorE errorKind;

  outcomeT  expQ[$];          // Pending outcomes, oldest first
  outcomeT  expNow;
  int       cycleCount = 0;

  `include "canFrameGen.svh"

  canDecoder UUT (
    .Clock_SP   (Clock_SP),
    .rstN       (rstN),
    .bitValid   (bitValid),
    .busBit     (busBit),
    .frameValid (frameValid),
    .frameInfo  (frameInfo),
    .frameError (frameError),
    .errorKind  (errorKind)
  );

  always #2 Clock_SP = ~Clock_SP;   // 4 ns period

  // ----------------------------------------
  // Checking
  // ----------------------------------------
  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    if (got !== exp)
      failRun($sformatf("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp));
  endtask

  // Outputs are settled at the falling edge
  always @(negedge Clock_SP)
  begin
    if (frameValid && frameError)
      failRun("frameValid and frameError were strobed in the same cycle");
    else if ((frameValid || frameError) && expQ.size() == 0)
      failRun("An outcome strobe arrived while no frame was pending");
    else if (frameValid || frameError)
    begin
      expNow = expQ.pop_front();
      checkValue("frameError", frameError, expNow.isError);
      if (expNow.isError)
        checkValue("errorKind", errorKind, expNow.kind);
      else
      begin
        checkValue("frameInfo.ide", frameInfo.ide, expNow.frame.ide);
        checkValue("frameInfo.rtr", frameInfo.rtr, expNow.frame.rtr);
        checkValue("frameInfo.id", frameInfo.id, expNow.frame.id);
        checkValue("frameInfo.dlc", frameInfo.dlc, expNow.frame.dlc);
        checkValue("frameInfo.data", frameInfo.data, expNow.frame.data);
        checkValue("frameInfo.srrWarn", frameInfo.srrWarn, expNow.frame.srrWarn);
        checkValue("frameInfo.resWarn", frameInfo.resWarn, expNow.frame.resWarn);
      end
    end
  end

  always @(posedge Clock_SP)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount > CycleLimit)
      failRun("Timeout: the run did not finish within its cycle limit");
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  // One bus bit, then 1 to 3 idle cycles
  task automatic sendBit(input bit level);
    int idle;
    idle = int'($urandom_range(1, 3));
    busBit   <= level;
    bitValid <= 1'b1;
    @(posedge Clock_SP);
    bitValid <= 1'b0;
    repeat (idle) @(posedge Clock_SP);
  endtask

  function automatic canFrameT randomFrame();
    canFrameT f;
    int       i;
    f     = '0;
    f.ide = 1'($urandom_range(0, 1));
    f.rtr = ($urandom_range(0, 3) == 0);              // One in four remote
    case ($urandom_range(0, 3))
      0:       f.id = '0;                             // Forces dominant stuff runs
      1:       f.id = '1;                             // Recessive runs
      default: f.id = IdBits'($urandom());
    endcase
    if (!f.ide)
      f.id = f.id & IdBits'(2 ** IdStdBits - 1);      // Std id in low bits
    if ($urandom_range(0, 3) == 0)
      f.dlc = DlcBits'($urandom_range(9, 15));
    else
      f.dlc = DlcBits'($urandom_range(0, 8));
    for (i = 0; i < dataBytes(f); i++)
      f.data[MaxDataBytes-1-i] = 8'($urandom());      // Unused bytes stay zero
    f.srrWarn = f.ide && ($urandom_range(0, 4) == 0); // SRR exists only if extended
    f.resWarn = ($urandom_range(0, 4) == 0);
    return f;
  endfunction

  // Kind 1 CRC flip, 3 missing stuff bit, 5 dominant fixed bit, else clean
  task automatic runFrame(input int kind);
    canFrameT f;
    outcomeT  exp;
    int       pos;
    int       i;
    f = randomFrame();
    if (kind == 3)
      f.id = '0;                                      // Stuff bit right after SOF run
    serialize(f);
    exp         = '0;
    exp.isError = 1'b1;
    case (kind)
      1:
      begin
        pos = dataStart + int'($urandom_range(0, rawBits.size() - 1 - dataStart));
        rawBits[pos] = ~rawBits[pos];                 // Stuffed after the flip
        stuffLine(1'($urandom_range(0, 1)));
        exp.kind = Crc;
      end
      3:
      begin
        stuffLine(1'($urandom_range(0, 1)));
        lineBits[firstStuff] = ~lineBits[firstStuff]; // Six equal bits
        exp.kind = Stuff;
      end
      5:
      begin
        stuffLine(1'($urandom_range(0, 1)));
        pos = int'($urandom_range(0, 8));             // Delimiters, then EOF bits
        lineBits[delimPos + ((pos == 0) ? 0 : pos + 1)] = 1'b0;
        exp.kind = Form;
      end
      default:
      begin
        stuffLine(1'($urandom_range(0, 1)));
        exp.isError = 1'b0;
        exp.frame   = f;
      end
    endcase
    if (expQ.size() != 0)
      failRun("A frame ended without any outcome strobe");
    else
    begin
      expQ.push_back(exp);
      for (i = 0; i < lineBits.size(); i++)
        sendBit(lineBits[i]);
      repeat (IdleRecessive + $urandom_range(0, 3)) sendBit(1'b1);  // Covers recovery
    end
  endtask

  initial
  begin
    int n;
    void'($urandom(78028));
    rstN     = 1'b0;
    bitValid = 1'b0;
    busBit   = 1'b1;
    repeat (2) @(posedge Clock_SP);
    rstN <= 1'b1;
    repeat (20) sendBit(1'b1);                        // No strobe on an idle bus
    for (n = 0; n < NumFrames; n++)
      runFrame(n % 6);                                // Clean frame after each error
    if (expQ.size() == 0)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
      failRun("The last frame produced no outcome strobe");
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
canPkg.sv
canBitDestuffer.sv
canCrc15.sv
canFieldDecoder.sv
canDecoder.sv
canDecoderTb.sv

// File: Bender.yml
package:
  name: can_decoder

sources:
  - canPkg.sv
  - canBitDestuffer.sv
  - canCrc15.sv
  - canFieldDecoder.sv
  - canDecoder.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - canDecoderTb.sv
